/* design/spiProtoPkg.sv */
// SPI frame-level types shared by the shift register and the transaction state machine
package spiProtoPkg;

    // one frame byte as it moves through the shift register
    typedef logic [7:0] spiByte;

    // rising sclk edges seen within the current byte
    // wraps from 7 back to 0 at the end of a byte
    typedef logic [2:0] bitCount;

    // transaction states, one frame per csN low period
    typedef enum logic [2:0] {
        // csN high, nothing going on
        idle,
        // shifting in the command byte
        getAddr,
        // command byte complete, address latched here
        decode,
        // memory data loaded into the shift register
        readLoad,
        // read byte going out on miso
        readShift,
        // write data coming in on mosi
        writeShift,
        // one-cycle memory write strobe
        writeCommit,
        // frame done, hold until csN goes high
        waitCsHigh
    } spiState;

    // LSB of the command byte, 1 selects a read
    localparam logic rwReadBit = 1'b1;

endpackage

/* design/memMapPkg.sv */
// memory geometry and address/data types for the byte memory behind the SPI slave
package memMapPkg;

    // seven address bits from the command byte
    localparam int memAddrWidth = 7;

    // one byte per address
    localparam int memDepth = 128;

    // byte address into the memory
    typedef logic [memAddrWidth-1:0] memAddr;

    // one stored byte
    typedef logic [7:0] memData;

endpackage

/* design/inputConditioner.sv */
// synchronizes, debounces and edge-detects one asynchronous input pin; one instance per SPI pin
module inputConditioner #(
    // stable clk cycles needed before a change is accepted
    parameter int waitTime = 3,
    // level of the output and the sync flops while in reset
    parameter logic resetLevel = 1'b0
) (
    input  logic clk,
    input  logic arstN,
    input  logic noisy,
    output logic conditioned,
    output logic risingEdge,
    output logic fallingEdge
);

    // counter must be able to hold waitTime itself
    localparam int cntWidth = (waitTime < 1) ? 1 : $clog2(waitTime + 1);

    logic syncMeta;
    logic syncOut;
    logic [cntWidth-1:0] stableCnt;

    // two-flop synchronizer
    // first flop may go metastable, second one settles it
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            syncMeta <= resetLevel;
            syncOut  <= resetLevel;
        end else begin
            syncMeta <= noisy;
            syncOut  <= syncMeta;
        end
    end

    // debounce
    // count cycles in which the synced level disagrees with the output,
    // any agreement in between restarts the count
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            stableCnt   <= '0;
            conditioned <= resetLevel;
            risingEdge  <= 1'b0;
            fallingEdge <= 1'b0;
        end else begin
            // pulses last one cycle unless set again below
            risingEdge  <= 1'b0;
            fallingEdge <= 1'b0;
            if (syncOut == conditioned) begin
                stableCnt <= '0;
            end else if (stableCnt == cntWidth'(waitTime)) begin
                // change held long enough, take it
                stableCnt   <= '0;
                conditioned <= syncOut;
                // edge pulse lines up with the new output level
                risingEdge  <= syncOut;
                fallingEdge <= !syncOut;
            end else begin
                stableCnt <= stableCnt + 1'b1;
            end
        end
    end

    // total latency pin to output is 2 sync cycles, waitTime count cycles
    // and one more for the output flop

endmodule

/* design/shiftRegister.sv */
// eight-bit SPI shift register: mosi in at the LSB, miso out from the MSB, parallel load for reads
module shiftRegister
    import spiProtoPkg::*;
    import memMapPkg::*;
(
    input  logic   clk,
    input  logic   arstN,
    input  logic   shiftEn,
    input  logic   serialIn,
    input  logic   srLoad,
    input  memData parallelIn,
    output spiByte parallelOut,
    output logic   serialOut
);

    spiByte shiftReg;

    // load wins over shift
    // the state machine never asks for both in one cycle anyway
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            shiftReg <= '0;
        end else if (srLoad) begin
            // read data from memory, MSB goes out first
            shiftReg <= parallelIn;
        end else if (shiftEn) begin
            // MSB first on the wire
            // new bit enters at the bottom
            shiftReg <= {shiftReg[$bits(spiByte)-2:0], serialIn};
        end
    end

    // whole byte visible for command decode and memory write
    assign parallelOut = shiftReg;

    // next outgoing bit
    // sampled into the miso flop on the falling sclk edge
    assign serialOut = shiftReg[$bits(spiByte)-1];

endmodule

/* design/dataMemory.sv */
// byte-wide register-file memory behind the SPI slave, written by write frames and read by read frames
module dataMemory
    import memMapPkg::*;
(
    input  logic              clk,
    input  logic              arstN,
    input  logic              memWe,
    input  memMapPkg::memAddr memAddr,
    input  memData            writeData,
    output memData            readData
);

    memData mem [memDepth];

    // whole array clears on reset so reads of unwritten bytes give zero
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            for (int i = 0; i < memDepth; i++) begin
                mem[i] <= '0;
            end
        end else if (memWe) begin
            mem[memAddr] <= writeData;
        end
    end

    // combinational read
    // address is already latched by the state machine
    assign readData = mem[memAddr];

endmodule

/* design/spiTransactionFsm.sv */
// per-frame control for the SPI memory slave: command decode, address latch, write strobe and miso
module spiTransactionFsm
    import spiProtoPkg::*;
    import memMapPkg::*;
(
    input  logic              clk,
    input  logic              arstN,
    input  logic              csN,
    input  logic              sclkRise,
    input  logic              sclkFall,
    input  spiByte            parallelOut,
    input  logic              serialOut,
    output logic              shiftEn,
    output logic              srLoad,
    output memMapPkg::memAddr memAddr,
    output logic              memWe,
    output logic              miso,
    output logic              misoOe
);

    spiState state;
    bitCount bitCnt;
    logic    lastBit;

    // shift only while a byte is actually on the wire
    assign shiftEn = sclkRise &&
                     ((state == getAddr) || (state == writeShift) || (state == readShift));

    // eighth rising edge of the current byte
    assign lastBit = shiftEn && (bitCnt == bitCount'(7));

    // strobes straight from the state
    // each of these states lasts exactly one cycle
    assign srLoad = (state == readLoad);
    assign memWe  = (state == writeCommit);

    // transaction state
    // csN high aborts from anywhere, so an unfinished write never reaches writeCommit
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            state <= idle;
        end else if (csN) begin
            state <= idle;
        end else begin
            case (state)
                // csN only goes low out of idle, so this is the frame start
                idle: begin
                    state <= getAddr;
                end
                getAddr: begin
                    if (lastBit) begin
                        state <= decode;
                    end
                end
                // command byte settled in the shift register this cycle
                decode: begin
                    if (parallelOut[0] == rwReadBit) begin
                        state <= readLoad;
                    end else begin
                        state <= writeShift;
                    end
                end
                // memory output valid now that the address is latched
                readLoad: begin
                    state <= readShift;
                end
                readShift: begin
                    if (lastBit) begin
                        state <= waitCsHigh;
                    end
                end
                writeShift: begin
                    if (lastBit) begin
                        state <= writeCommit;
                    end
                end
                writeCommit: begin
                    state <= waitCsHigh;
                end
                // no bursts, ignore further clocks until csN rises
                waitCsHigh: begin
                    state <= waitCsHigh;
                end
                default: begin
                    state <= idle;
                end
            endcase
        end
    end

    // bit counter
    // wraps on its own after eight shifts so no clear between command and data byte
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            bitCnt <= '0;
        end else if (csN || (state == idle)) begin
            bitCnt <= '0;
        end else if (shiftEn) begin
            bitCnt <= bitCnt + 1'b1;
        end
    end

    // address latch
    // upper seven bits of the command byte, read/write bit dropped
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            memAddr <= '0;
        end else if (state == decode) begin
            memAddr <= parallelOut[$bits(spiByte)-1 -: memAddrWidth];
        end
    end

    // miso flop, updated on falling sclk only
    // first fall in readShift puts out the MSB and raises misoOe,
    // the fall after the eighth read bit lands in waitCsHigh and drops both
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            miso   <= 1'b0;
            misoOe <= 1'b0;
        end else if (csN) begin
            miso   <= 1'b0;
            misoOe <= 1'b0;
        end else if (sclkFall) begin
            if (state == readShift) begin
                miso   <= serialOut;
                misoOe <= 1'b1;
            end else begin
                miso   <= 1'b0;
                misoOe <= 1'b0;
            end
        end
    end

endmodule

/* design/spiMemorySlave.sv */
// top level of the SPI mode 0 slave with a 128-byte memory; pins in, miso plus its enable out
module spiMemorySlave
    import spiProtoPkg::*;
    import memMapPkg::*;
#(
    // debounce length for all three pins
    parameter int waitTime = 3
) (
    input  logic clk,
    input  logic arstN,
    input  logic sclk,
    input  logic csN,
    input  logic mosi,
    output logic miso,
    output logic misoOe
);

    logic   csClean;
    logic   sclkRise;
    logic   sclkFall;
    logic   mosiClean;
    logic   shiftEn;
    logic   srLoad;
    logic   memWe;
    logic   serialOut;
    memAddr addr;
    spiByte parallelOut;
    memData readData;

    // chip select idles high, so it resets high
    // only its level is used
    inputConditioner #(
        .waitTime  (waitTime),
        .resetLevel(1'b1)
    ) csCond (
        .clk        (clk),
        .arstN      (arstN),
        .noisy      (csN),
        .conditioned(csClean),
        .risingEdge (),
        .fallingEdge()
    );

    // sclk is only needed as edge pulses
    inputConditioner #(
        .waitTime  (waitTime),
        .resetLevel(1'b0)
    ) sclkCond (
        .clk        (clk),
        .arstN      (arstN),
        .noisy      (sclk),
        .conditioned(),
        .risingEdge (sclkRise),
        .fallingEdge(sclkFall)
    );

    // mosi level goes straight into the shift register
    inputConditioner #(
        .waitTime  (waitTime),
        .resetLevel(1'b0)
    ) mosiCond (
        .clk        (clk),
        .arstN      (arstN),
        .noisy      (mosi),
        .conditioned(mosiClean),
        .risingEdge (),
        .fallingEdge()
    );

    shiftRegister shiftReg (
        .clk        (clk),
        .arstN      (arstN),
        .shiftEn    (shiftEn),
        .serialIn   (mosiClean),
        .srLoad     (srLoad),
        .parallelIn (readData),
        .parallelOut(parallelOut),
        .serialOut  (serialOut)
    );

    // write data is the shift register contents after the sixteenth bit
    dataMemory dataMem (
        .clk      (clk),
        .arstN    (arstN),
        .memWe    (memWe),
        .memAddr  (addr),
        .writeData(parallelOut),
        .readData (readData)
    );

    spiTransactionFsm txnFsm (
        .clk        (clk),
        .arstN      (arstN),
        .csN        (csClean),
        .sclkRise   (sclkRise),
        .sclkFall   (sclkFall),
        .parallelOut(parallelOut),
        .serialOut  (serialOut),
        .shiftEn    (shiftEn),
        .srLoad     (srLoad),
        .memAddr    (addr),
        .memWe      (memWe),
        .miso       (miso),
        .misoOe     (misoOe)
    );

endmodule

/* tb/tbSpiMemorySlave.sv */
// testbench for the SPI memory slave; runs a table of read, write, aborted and glitched frames
module tbSpiMemorySlave;

    // kinds of frame the master can send
    typedef enum logic [1:0] {
        opRead,
        opWrite,
        opAbort,
        opGlitch
    } frameOp;

    localparam int tableSize = 32;
    localparam int memSize = 128;
    // sclk phase length in clk cycles
    localparam int halfBit = 10;
    // command byte plus half a data byte, then csN goes high
    localparam int abortBits = 12;
    // idle clk cycles between frames
    localparam int gapCycles = 20;
    // upper bound for misoOe to drop once csN is high
    localparam int oeTimeout = 50;

    logic clk;
    logic arstN;
    logic sclk;
    logic csN;
    logic mosi;
    logic miso;
    logic misoOe;

    // stimulus table, one frame per entry
    frameOp     tabOp   [tableSize];
    logic [6:0] tabAddr [tableSize];
    logic [7:0] tabData [tableSize];
    logic [7:0] tabExp  [tableSize];
    int         tabCount;

    // reference memory, changed only by complete writes
    logic [7:0]  refMem [memSize];
    logic [15:0] lfsrState;
    int          mismatchCount;
    int          timeoutCount;

    spiMemorySlave #(
        .waitTime(3)
    ) u_spiMemorySlave (
        .clk   (clk),
        .arstN (arstN),
        .sclk  (sclk),
        .csN   (csN),
        .mosi  (mosi),
        .miso  (miso),
        .misoOe(misoOe)
    );

    // 40 unit clock period
    always #20 clk = ~clk;

    // one step of a 16-bit Galois LFSR with taps 16 14 13 11
    function automatic logic [15:0] stepLfsr(input logic [15:0] s);
        logic [15:0] n;
        n = s >> 1;
        if (s[0]) begin
            n = n ^ 16'hB400;
        end
        return n;
    endfunction

    // collect count random bits, one LFSR step per bit, MSB first
    task automatic takeBits(input int count, output logic [7:0] value);
        value = 8'h00;
        for (int i = 0; i < count; i++) begin
            lfsrState = stepLfsr(lfsrState);
            value = {value[6:0], lfsrState[0]};
        end
    endtask

    // append one frame and work out what a read should return at that point
    task automatic addEntry(input frameOp op, input logic [6:0] addr, input logic [7:0] data);
        tabOp[tabCount] = op;
        tabAddr[tabCount] = addr;
        tabData[tabCount] = data;
        // aborted writes never land in memory
        if ((op == opWrite) || (op == opGlitch)) begin
            refMem[addr] = data;
        end
        tabExp[tabCount] = refMem[addr];
        tabCount++;
    endtask

    task automatic buildTable();
        logic [7:0] rnd;
        logic [7:0] dat;
        logic [6:0] wAddr [6];
        for (int i = 0; i < memSize; i++) begin
            refMem[i] = 8'h00;
        end
        tabCount = 0;
        // memory comes out of reset cleared
        addEntry(opRead, 7'h00, 8'h00);
        addEntry(opRead, 7'h7f, 8'h00);
        takeBits(7, rnd);
        addEntry(opRead, rnd[6:0], 8'h00);
        // random writes, then read every one back
        for (int i = 0; i < 6; i++) begin
            takeBits(7, rnd);
            takeBits(8, dat);
            wAddr[i] = rnd[6:0];
            addEntry(opWrite, wAddr[i], dat);
        end
        for (int i = 0; i < 6; i++) begin
            addEntry(opRead, wAddr[i], 8'h00);
        end
        // aborted writes, to a written byte and to a random one
        takeBits(8, dat);
        addEntry(opAbort, wAddr[0], dat);
        addEntry(opRead, wAddr[0], 8'h00);
        takeBits(7, rnd);
        takeBits(8, dat);
        addEntry(opAbort, rnd[6:0], dat);
        addEntry(opRead, rnd[6:0], 8'h00);
        // short mosi pulses during the data byte
        takeBits(7, rnd);
        takeBits(8, dat);
        addEntry(opGlitch, rnd[6:0], dat);
        addEntry(opRead, rnd[6:0], 8'h00);
        // overwrite one byte, check it and a neighbour entry
        takeBits(8, dat);
        addEntry(opWrite, wAddr[2], dat);
        addEntry(opRead, wAddr[2], 8'h00);
        addEntry(opRead, wAddr[5], 8'h00);
    endtask

    // n rising clk edges, then the usual drive offset
    task automatic waitClocks(input int n);
        repeat (n) begin
            @(posedge clk);
        end
        #2;
    endtask

    task automatic waitOeLow();
        int cycles;
        cycles = 0;
        while (misoOe && (cycles < oeTimeout)) begin
            waitClocks(1);
            cycles++;
        end
        if (misoOe) begin
            $display("timeout: misoOe still high %0d cycles after csN went high", oeTimeout);
            timeoutCount++;
        end
    endtask

    // SPI mode 0 master sending one frame of bitTotal bits
    task automatic runFrame(input logic [15:0] frameBits, input int bitTotal,
                            input logic isRead, input logic glitch,
                            output logic [7:0] readByte);
        logic [15:0] txBits;
        logic        expOe;
        readByte = 8'h00;
        txBits = frameBits;
        csN = 1'b0;
        mosi = txBits[15];
        waitClocks(halfBit);
        for (int i = 0; i < bitTotal; i++) begin
            if (i > 0) begin
                // falling phase, next bit goes out
                sclk = 1'b0;
                txBits = txBits << 1;
                mosi = txBits[15];
                if (glitch && (i >= 8)) begin
                    // two-cycle flip straddling the rising edge
                    // an unfiltered flip would be shifted in
                    waitClocks(halfBit - 1);
                    mosi = ~mosi;
                    waitClocks(1);
                end else begin
                    waitClocks(halfBit);
                end
            end
            // sample just before the rising edge
            expOe = isRead && (i >= 8);
            if (misoOe !== expOe) begin
                $display("Mismatch at %0t: misoOe is %b at bit %0d, expected %b",
                         $time, misoOe, i, expOe);
                mismatchCount++;
            end
            if (expOe) begin
                readByte = {readByte[6:0], miso};
            end
            sclk = 1'b1;
            if (glitch && (i >= 8)) begin
                // flip ends one cycle after the rising edge
                waitClocks(1);
                mosi = ~mosi;
                waitClocks(halfBit - 1);
            end else begin
                waitClocks(halfBit);
            end
        end
        // final falling edge ends the read byte
        sclk = 1'b0;
        waitClocks(halfBit);
        if (misoOe !== 1'b0) begin
            $display("Mismatch at %0t: misoOe high after the last falling sclk", $time);
            mismatchCount++;
        end
        csN = 1'b1;
        mosi = 1'b0;
        waitOeLow();
        // misoOe stays low the whole time csN is high
        for (int c = 0; c < gapCycles; c++) begin
            waitClocks(1);
            if (misoOe !== 1'b0) begin
                $display("Mismatch at %0t: misoOe high while csN is high", $time);
                mismatchCount++;
            end
        end
    endtask

    initial begin
        logic [15:0] frameBits;
        logic [7:0]  readByte;
        int          bitTotal;
        clk = 1'b0;
        arstN = 1'b0;
        sclk = 1'b0;
        csN = 1'b1;
        mosi = 1'b0;
        mismatchCount = 0;
        timeoutCount = 0;
        lfsrState = 16'd61;
        buildTable();
        // reset held for 8 cycles
        repeat (8) begin
            @(posedge clk);
        end
        #2;
        arstN = 1'b1;
        waitClocks(gapCycles);
        for (int e = 0; e < tabCount; e++) begin
            // command byte is address then read/write bit
            if (tabOp[e] == opRead) begin
                frameBits = {tabAddr[e], 1'b1, 8'h00};
            end else begin
                frameBits = {tabAddr[e], 1'b0, tabData[e]};
            end
            bitTotal = (tabOp[e] == opAbort) ? abortBits : 16;
            runFrame(frameBits, bitTotal, tabOp[e] == opRead, tabOp[e] == opGlitch, readByte);
            if ((tabOp[e] == opRead) && (readByte !== tabExp[e])) begin
                $display("Mismatch at %0t: read of address %h returned %h, expected %h",
                         $time, tabAddr[e], readByte, tabExp[e]);
                mismatchCount++;
            end
        end
        $display("run complete: %0d frames, %0d mismatches, %0d timeouts",
                 tabCount, mismatchCount, timeoutCount);
        if ((mismatchCount + timeoutCount) == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

/* sources.f */
design/spiProtoPkg.sv
design/memMapPkg.sv
design/inputConditioner.sv
design/shiftRegister.sv
design/dataMemory.sv
design/spiTransactionFsm.sv
design/spiMemorySlave.sv
tb/tbSpiMemorySlave.sv

/* Makefile */
TOP = tbSpiMemorySlave

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f sources.f --top-module $(TOP)

sim:
	verilator --binary --timing -f sources.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "^NO ERRORS$$" sim.log

clean:
	rm -rf obj_dir sim.log
